// File: rtl/fifo_if.sv
/*
  Output queue bundle.
  Write and read requests on the producer side, show-ahead data and fill
  status on the storage side.
*/
`timescale 1ns/1ps

interface fifo_if import int_pkg::*; #(parameter type T = logic) ();

  logic             wrreq;
  T                 data;
  logic             rdreq;
  T                 q;
  logic             empty;
  logic             full;
  logic [CNT_W-1:0] usedw;

  modport producer (
    output wrreq, data, rdreq,
    input  q, empty, full, usedw
  );

  modport storage (
    input  wrreq, data, rdreq,
    output q, empty, full, usedw
  );

endinterface

// File: rtl/int_math.sv
/*
  Intersection math, four stages, free running.
  Moves the ray into the triangle's unit space and tests it against the
  unit triangle, giving sign-corrected numerators and the denominator.
*/
`timescale 1ns/1ps

module int_math import int_pkg::*; (
  input  logic           clk,
  input  int_cacheline_t int_cacheline,
  input  ray_vec_t       ray_vec,
  output logic           hit,
  output bari_t          bari
);

  // Unpacked views of the matrix and the ray
  logic signed [COORD_W-1:0] m [3][3];
  logic signed [COORD_W-1:0] org [3];
  logic signed [COORD_W-1:0] dir [3];

  always_comb begin
    m[0][0] = int_cacheline.m0.x;
    m[0][1] = int_cacheline.m0.y;
    m[0][2] = int_cacheline.m0.z;
    m[1][0] = int_cacheline.m1.x;
    m[1][1] = int_cacheline.m1.y;
    m[1][2] = int_cacheline.m1.z;
    m[2][0] = int_cacheline.m2.x;
    m[2][1] = int_cacheline.m2.y;
    m[2][2] = int_cacheline.m2.z;
    org[0]  = ray_vec.origin.x;
    org[1]  = ray_vec.origin.y;
    org[2]  = ray_vec.origin.z;
    dir[0]  = ray_vec.dir.x;
    dir[1]  = ray_vec.dir.y;
    dir[2]  = ray_vec.dir.z;
  end

  // Stage 1 forms the eighteen products
  logic signed [2*COORD_W-1:0] po_q [3][3];
  logic signed [2*COORD_W-1:0] pd_q [3][3];
  vec3_t                       tr_q;

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        po_q[r][c] <= m[r][c] * org[c];
        pd_q[r][c] <= m[r][c] * dir[c];
      end
    end
    tr_q <= int_cacheline.translate;
  end

  // Stage 2 sums into the transformed origin and direction
  logic signed [XF_W-1:0] tr_ext [3];
  logic signed [XF_W-1:0] o_xf_q [3];
  logic signed [XF_W-1:0] d_xf_q [3];

  always_comb begin
    tr_ext[0] = XF_W'(tr_q.x);
    tr_ext[1] = XF_W'(tr_q.y);
    tr_ext[2] = XF_W'(tr_q.z);
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      o_xf_q[r] <= XF_W'(po_q[r][0]) + XF_W'(po_q[r][1]) + XF_W'(po_q[r][2]) + tr_ext[r];
      d_xf_q[r] <= XF_W'(pd_q[r][0]) + XF_W'(pd_q[r][1]) + XF_W'(pd_q[r][2]);
    end
  end

  // Stage 3 forms numerators over the common denominator d'z
  logic signed [BARI_W-1:0] tn_c;
  logic signed [BARI_W-1:0] den_c;
  logic signed [BARI_W-1:0] tn_q, un_q, vn_q, den_q;

  always_comb begin
    tn_c  = -BARI_W'(o_xf_q[2]);
    den_c = BARI_W'(d_xf_q[2]);
  end

  always_ff @(posedge clk) begin
    tn_q  <= tn_c;
    den_q <= den_c;
    un_q  <= BARI_W'(o_xf_q[0]) * den_c + tn_c * BARI_W'(d_xf_q[0]);
    vn_q  <= BARI_W'(o_xf_q[1]) * den_c + tn_c * BARI_W'(d_xf_q[1]);
  end

  // Stage 4 makes the denominator positive and then tests
  bari_t                  fix;
  logic signed [BARI_W:0] uv_sum;
  logic                   hit_c;

  always_comb begin
    if (den_q < 0) begin
      fix.t_num = -tn_q;
      fix.u_num = -un_q;
      fix.v_num = -vn_q;
      fix.den   = -den_q;
    end else begin
      fix.t_num = tn_q;
      fix.u_num = un_q;
      fix.v_num = vn_q;
      fix.den   = den_q;
    end
    uv_sum = (BARI_W+1)'(fix.u_num) + (BARI_W+1)'(fix.v_num);
    hit_c  = (fix.den != 0) && (fix.t_num > 0) && (fix.u_num >= 0) &&
             (fix.v_num >= 0) && (uv_sum <= (BARI_W+1)'(fix.den));
  end

  always_ff @(posedge clk) begin
    bari <= fix;
    hit  <= hit_c;
  end

endmodule

// File: rtl/int_pkg.sv
/*
  Shared sizes and record types for the ray-triangle intersection stage.
  Coordinates are signed integers and the test yields numerators over a
  common denominator.
*/
package int_pkg;

  // Arithmetic widths
  localparam int COORD_W = 12;
  localparam int XF_W    = 26;
  localparam int BARI_W  = 54;

  // Pipeline and queue sizing
  localparam int MATH_LATENCY = 4;
  localparam int FIFO_DEPTH   = 8;
  localparam int CNT_W        = 4;
  localparam int PTR_W        = 3;

  typedef struct packed {
    logic signed [COORD_W-1:0] x;
    logic signed [COORD_W-1:0] y;
    logic signed [COORD_W-1:0] z;
  } vec3_t;

  // Rows of the world-to-unit-space matrix, then the translate
  typedef struct packed {
    vec3_t m0;
    vec3_t m1;
    vec3_t m2;
    vec3_t translate;
  } int_cacheline_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

  typedef struct packed {
    logic [7:0] rayID;
  } ray_info_t;

  typedef logic [15:0] triID_t;

  // Leaf list position and triangles still to go
  typedef struct packed {
    logic [7:0] lindex;
    logic [7:0] lnum_left;
  } ln_tri_t;

  typedef struct packed {
    int_cacheline_t tri_cacheline;
    ray_vec_t       ray_vec;
    ray_info_t      ray_info;
    triID_t         triID;
    ln_tri_t        ln_tri;
  } icache_to_int_t;

  typedef struct packed {
    logic signed [BARI_W-1:0] t_num;
    logic signed [BARI_W-1:0] u_num;
    logic signed [BARI_W-1:0] v_num;
    logic signed [BARI_W-1:0] den;
  } bari_t;

  typedef struct packed {
    ray_info_t ray_info;
    triID_t    triID;
    logic      hit;
    logic      is_last;
    bari_t     bari;
  } int_to_list_t;

  typedef struct packed {
    ray_info_t ray_info;
    ln_tri_t   ln_tri;
  } leaf_info_t;

  typedef struct packed {
    ray_info_t ray_info;
    triID_t    triID;
    ln_tri_t   ln_tri;
  } int_side_t;

endpackage

// File: rtl/int_unit.sv
/*
  Ray-triangle intersection unit.
  Runs the math and a side pipe in parallel, decides the last triangle
  of a leaf and sorts results into the list and leaf-arbiter queues.
*/
`timescale 1ns/1ps

module int_unit import int_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,

  input  logic           icache_to_int_valid,
  input  icache_to_int_t icache_to_int_data,
  output logic           icache_to_int_stall,

  output logic           int_to_list_valid,
  output int_to_list_t   int_to_list_data,
  input  logic           int_to_list_stall,

  output logic           int_to_larb_valid,
  output leaf_info_t     int_to_larb_data,
  input  logic           int_to_larb_stall
);

  // Math block, fed straight from the input record
  logic  hit;
  bari_t bari;

  int_math u_math (
    .clk,
    .int_cacheline (icache_to_int_data.tri_cacheline),
    .ray_vec       (icache_to_int_data.ray_vec),
    .hit,
    .bari
  );

  // Counters move to the next triangle before entering the side pipe
  int_side_t side_in;
  int_side_t side_out;
  logic      side_valid;
  logic      side_stall;

  always_comb begin
    side_in.ray_info         = icache_to_int_data.ray_info;
    side_in.triID            = icache_to_int_data.triID;
    side_in.ln_tri.lindex    = icache_to_int_data.ln_tri.lindex + 1'b1;
    side_in.ln_tri.lnum_left = icache_to_int_data.ln_tri.lnum_left - 1'b1;
  end

  fifo_if #(.T(int_to_list_t)) list_q ();
  fifo_if #(.T(leaf_info_t))   larb_q ();

  // Credit is what the fuller queue has left
  logic [CNT_W-1:0] max_used;
  logic [CNT_W:0]   credit_limit;

  assign max_used     = (list_q.usedw > larb_q.usedw) ? list_q.usedw : larb_q.usedw;
  assign credit_limit = (CNT_W+1)'(FIFO_DEPTH) - {1'b0, max_used};

  pipe_valid_stall u_side_pipe (
    .clk,
    .rst_n,
    .us_valid     (icache_to_int_valid),
    .us_data      (side_in),
    .us_stall     (side_stall),
    .ds_valid     (side_valid),
    .ds_data      (side_out),
    .credit_limit (credit_limit)
  );

  assign icache_to_int_stall = icache_to_int_valid & side_stall;

  logic is_last;
  assign is_last = (side_out.ln_tri.lnum_left == '0);

  // Hits and leaf ends go to the list, everything else continues the leaf
  always_comb begin
    list_q.data.ray_info = side_out.ray_info;
    list_q.data.triID    = side_out.triID;
    list_q.data.hit      = hit;
    list_q.data.is_last  = is_last;
    list_q.data.bari     = bari;
    larb_q.data.ray_info = side_out.ray_info;
    larb_q.data.ln_tri   = side_out.ln_tri;
  end

  assign list_q.wrreq = side_valid & (hit | is_last);
  assign larb_q.wrreq = side_valid & ~is_last;

  sync_fifo #(.T(int_to_list_t)) u_list_fifo (
    .clk,
    .rst_n,
    .port (list_q.storage)
  );

  sync_fifo #(.T(leaf_info_t)) u_larb_fifo (
    .clk,
    .rst_n,
    .port (larb_q.storage)
  );

  assign int_to_list_valid = ~list_q.empty;
  assign int_to_list_data  = list_q.q;
  assign list_q.rdreq      = int_to_list_valid & ~int_to_list_stall;

  assign int_to_larb_valid = ~larb_q.empty;
  assign int_to_larb_data  = larb_q.q;
  assign larb_q.rdreq      = int_to_larb_valid & ~int_to_larb_stall;

  // Credit must leave room in both queues for any result leaving the pipe
  a_credit_room: assert property (
    @(posedge clk) disable iff (!rst_n)
    side_valid |-> !list_q.full && !larb_q.full
  ) else $error("result left the pipe with a full output queue");

endmodule

// File: rtl/pipe_valid_stall.sv
/*
  Side pipeline for the bookkeeping fields.
  Delays valid and data by the math latency and limits the number of
  items in flight to the credit the output queues still have.
*/
`timescale 1ns/1ps

module pipe_valid_stall import int_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           us_valid,
  input  int_side_t      us_data,
  output logic           us_stall,
  output logic           ds_valid,
  output int_side_t      ds_data,
  input  logic [CNT_W:0] credit_limit
);

  logic [MATH_LATENCY-1:0] vld;
  int_side_t               dat [MATH_LATENCY];
  logic [CNT_W:0]          in_flight;
  logic                    accept;
  logic                    leave;

  // No room left once the in-flight count meets the credit
  assign us_stall = (in_flight >= credit_limit);
  assign accept   = us_valid & ~us_stall;
  assign leave    = vld[MATH_LATENCY-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[MATH_LATENCY-2:0], accept};
    end
  end

  always_ff @(posedge clk) begin
    dat[0] <= us_data;
    for (int i = 1; i < MATH_LATENCY; i++) begin
      dat[i] <= dat[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      case ({accept, leave})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  assign ds_valid = vld[MATH_LATENCY-1];
  assign ds_data  = dat[MATH_LATENCY-1];

  // The counter tracks the shift line, so it can never pass its depth
  a_in_flight_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_flight <= (CNT_W+1)'(MATH_LATENCY)
  ) else $error("side pipe holds more items than its depth");

endmodule

// File: rtl/sync_fifo.sv
/*
  Show-ahead synchronous FIFO.
  Circular storage with the head word always on q, plus full, empty and
  a used-word count for the credit logic.
*/
`timescale 1ns/1ps

module sync_fifo import int_pkg::*; #(
  parameter type T = logic
) (
  input logic     clk,
  input logic     rst_n,
  fifo_if.storage port
);

  T                 mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = port.wrreq & ~port.full;
  assign do_rd = port.rdreq & ~port.empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= port.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is visible without a read
  assign port.q     = mem[rd_ptr];
  assign port.empty = (count == '0);
  assign port.full  = (count == CNT_W'(FIFO_DEPTH));
  assign port.usedw = count;

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    port.rdreq |-> !port.empty
  ) else $error("FIFO read while empty");

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    port.wrreq |-> !port.full
  ) else $error("FIFO written while full");

endmodule

// File: tests/int_tb_ref.svh
/*
  Reference model for the intersection stage.
  Gives the list and leaf-arbiter records one triangle should produce.
*/
`ifndef INT_TB_REF_SVH
`define INT_TB_REF_SVH

function automatic longint row_dot(input vec3_t row, input vec3_t v);
  return longint'(row.x) * longint'(v.x) + longint'(row.y) * longint'(v.y) +
         longint'(row.z) * longint'(v.z);
endfunction

function automatic int_to_list_t ref_list(input icache_to_int_t d);
  int_to_list_t   rec;
  int_cacheline_t c;
  longint         ox, oy, oz, dx, dy, dz;
  longint         tn, un, vn, den;
  c  = d.tri_cacheline;
  // Ray in the triangle's unit space
  ox = row_dot(c.m0, d.ray_vec.origin) + longint'(c.translate.x);
  oy = row_dot(c.m1, d.ray_vec.origin) + longint'(c.translate.y);
  oz = row_dot(c.m2, d.ray_vec.origin) + longint'(c.translate.z);
  dx = row_dot(c.m0, d.ray_vec.dir);
  dy = row_dot(c.m1, d.ray_vec.dir);
  dz = row_dot(c.m2, d.ray_vec.dir);
  tn  = -oz;
  den = dz;
  un  = ox * den + tn * dx;
  vn  = oy * den + tn * dy;
  if (den < 0) begin
    tn  = -tn;
    un  = -un;
    vn  = -vn;
    den = -den;
  end
  rec.ray_info    = d.ray_info;
  rec.triID       = d.triID;
  rec.hit         = (den != 0) && (tn > 0) && (un >= 0) && (vn >= 0) && (un + vn <= den);
  rec.is_last     = (8'(d.ln_tri.lnum_left - 8'd1) == 8'd0);
  rec.bari.t_num  = BARI_W'(tn);
  rec.bari.u_num  = BARI_W'(un);
  rec.bari.v_num  = BARI_W'(vn);
  rec.bari.den    = BARI_W'(den);
  return rec;
endfunction

// Continuation moves one triangle along the leaf
function automatic leaf_info_t ref_larb(input icache_to_int_t d);
  leaf_info_t rec;
  rec.ray_info         = d.ray_info;
  rec.ln_tri.lindex    = d.ln_tri.lindex + 8'd1;
  rec.ln_tri.lnum_left = d.ln_tri.lnum_left - 8'd1;
  return rec;
endfunction

`endif

// File: tests/int_tb.sv
/*
  Testbench for the intersection unit.
  LFSR triangles go in, the reference model fills two scoreboards and
  concurrent assertions check every output transfer against them.
*/
`timescale 1ns/1ps

module int_tb import int_pkg::*; ();

  localparam int LIMIT    = 5000;
  localparam int SB_DEPTH = 1024;

  logic           clk;
  logic           rst_n;
  logic           icache_to_int_valid;
  icache_to_int_t icache_to_int_data;
  logic           icache_to_int_stall;
  logic           int_to_list_valid;
  int_to_list_t   int_to_list_data;
  logic           int_to_list_stall;
  logic           int_to_larb_valid;
  leaf_info_t     int_to_larb_data;
  logic           int_to_larb_stall;

  `include "int_tb_ref.svh"

  int_unit DUT (.*);

  always #2 clk = ~clk;

  // Scoreboards written on acceptance and read on output transfers
  int_to_list_t exp_list [SB_DEPTH];
  leaf_info_t   exp_larb [SB_DEPTH];
  int_to_list_t list_head;
  leaf_info_t   larb_head;
  int_to_list_t exp_rec;
  int           list_wr = 0, list_rd = 0, larb_wr = 0, larb_rd = 0;
  int           errors = 0, tests = 0, start_errors = 0, next_id = 0;
  int           accepted = 0, hits = 0, intake_stalls = 0;
  logic [31:0]  lfsr;
  logic         accepted_any = 1'b0;
  logic         stall_mode;
  logic         list_xfer;
  logic         larb_xfer;

  assign list_xfer = int_to_list_valid & ~int_to_list_stall;
  assign larb_xfer = int_to_larb_valid & ~int_to_larb_stall;
  assign list_head = exp_list[list_rd % SB_DEPTH];
  assign larb_head = exp_larb[larb_rd % SB_DEPTH];

  always @(posedge clk) begin
    if (rst_n && icache_to_int_valid && !icache_to_int_stall) begin
      exp_rec = ref_list(icache_to_int_data);
      accepted_any <= 1'b1;
      accepted     <= accepted + 1;
      hits         <= hits + int'(exp_rec.hit);
      if (exp_rec.hit || exp_rec.is_last) begin
        exp_list[list_wr % SB_DEPTH] <= exp_rec;
        list_wr <= list_wr + 1;
      end
      if (!exp_rec.is_last) begin
        exp_larb[larb_wr % SB_DEPTH] <= ref_larb(icache_to_int_data);
        larb_wr <= larb_wr + 1;
      end
    end
    if (rst_n && icache_to_int_stall) intake_stalls <= intake_stalls + 1;
    if (rst_n && list_xfer) list_rd <= list_rd + 1;
    if (rst_n && larb_xfer) larb_rd <= larb_rd + 1;
  end

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !accepted_any |-> !int_to_list_valid && !int_to_larb_valid) else begin
    errors++;
    $display("An output went valid before any triangle was accepted, at %0t", $time);
  end
  a_list_extra: assert property (@(posedge clk) disable iff (!rst_n)
    list_xfer |-> list_rd != list_wr) else begin
    errors++;
    $display("List output sent a record that was not expected, at %0t", $time);
  end
  a_list_data: assert property (@(posedge clk) disable iff (!rst_n)
    list_xfer && list_rd != list_wr |-> int_to_list_data == list_head) else begin
    errors++;
    $display("Error at %0t: int_to_list_data is %h, expected %h", $time,
             $sampled(int_to_list_data), $sampled(list_head));
  end
  a_larb_extra: assert property (@(posedge clk) disable iff (!rst_n)
    larb_xfer |-> larb_rd != larb_wr) else begin
    errors++;
    $display("Leaf-arbiter output sent a record that was not expected, at %0t", $time);
  end
  a_larb_data: assert property (@(posedge clk) disable iff (!rst_n)
    larb_xfer && larb_rd != larb_wr |-> int_to_larb_data == larb_head) else begin
    errors++;
    $display("Error at %0t: int_to_larb_data is %h, expected %h", $time,
             $sampled(int_to_larb_data), $sampled(larb_head));
  end
  a_list_hold: assert property (@(posedge clk) disable iff (!rst_n)
    int_to_list_valid && int_to_list_stall |=>
    int_to_list_valid && $stable(int_to_list_data)) else begin
    errors++;
    $display("List output dropped or changed its record while stalled, at %0t", $time);
  end
  a_larb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    int_to_larb_valid && int_to_larb_stall |=>
    int_to_larb_valid && $stable(int_to_larb_data)) else begin
    errors++;
    $display("Leaf-arbiter output dropped or changed its record while stalled, at %0t", $time);
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic signed [COORD_W-1:0] rand_coord(input int bits, input int offset);
    return COORD_W'(int'(rnd(bits)) - offset);
  endfunction

  // Near-identity matrix and rays aimed at the unit triangle
  function automatic icache_to_int_t make_tri(input int id);
    icache_to_int_t d;
    d = '0;
    d.tri_cacheline.m0.x        = 12'sd1;
    d.tri_cacheline.m1.y        = 12'sd1;
    d.tri_cacheline.m2.z        = 12'sd1;
    d.tri_cacheline.m0.z        = (rnd(2) == 0) ? rand_coord(1, 1) : 12'sd0;
    d.tri_cacheline.m1.z        = (rnd(2) == 0) ? rand_coord(1, 1) : 12'sd0;
    d.tri_cacheline.translate.z = rand_coord(1, 1);
    d.ray_vec.origin.x          = rand_coord(1, 0);
    d.ray_vec.origin.y          = rand_coord(1, 0);
    d.ray_vec.origin.z          = rand_coord(3, -1);
    d.ray_vec.dir.x             = rand_coord(2, 2);
    d.ray_vec.dir.y             = rand_coord(2, 2);
    d.ray_vec.dir.z             = rand_coord(3, 4);
    d.ray_info.rayID            = 8'(rnd(8));
    d.triID                     = 16'(id);
    d.ln_tri.lindex             = 8'(rnd(8));
    d.ln_tri.lnum_left          = 8'(rnd(2) % 3 + 1);
    return d;
  endfunction

  task automatic drive_stalls();
    int_to_list_stall <= stall_mode && (rnd(2) != 0);
    int_to_larb_stall <= stall_mode && (rnd(2) != 0);
  endtask

  task automatic abort(input string why);
    $display("Timeout at %0t: %s", $time, why);
    $display("Checks failed");
    $finish;
  endtask

  task automatic run_triangles(input int count);
    int sent;
    int waited;
    sent   = 0;
    waited = 0;
    icache_to_int_valid <= 1'b1;
    icache_to_int_data  <= make_tri(next_id);
    while (sent < count) begin
      @(posedge clk);
      drive_stalls();
      waited++;
      if (!icache_to_int_stall) begin
        sent++;
        next_id++;
        waited = 0;
        if (sent < count) icache_to_int_data <= make_tri(next_id);
        else icache_to_int_valid <= 1'b0;
      end
      if (waited > LIMIT) abort("intake stayed stalled");
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      drive_stalls();
      waited++;
      if (waited > LIMIT) abort("expected records never left the outputs");
    end while (list_rd != list_wr || larb_rd != larb_wr);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - start_errors);
    start_errors = errors;
  endtask

  initial begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    lfsr                = 32'hdb71_940a;
    stall_mode          = 1'b0;
    icache_to_int_valid = 1'b0;
    icache_to_int_data  = '0;
    int_to_list_stall   = 1'b0;
    int_to_larb_stall   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (10) @(posedge clk);
    finish_test("reset_idle");
    run_triangles(40);
    drain();
    finish_test("in_order");
    stall_mode = 1'b1;
    run_triangles(100);
    drain();
    stall_mode = 1'b0;
    a_intake_stalled: assert (intake_stalls != 0) else begin
      errors++;
      $display("Intake never stalled while the output queues were held");
    end
    a_hit_mix: assert (hits != 0 && hits != accepted) else begin
      errors++;
      $display("Stimulus did not produce both hits and misses");
    end
    finish_test("backpressure");
    $display("%0d tests, %0d triangles, %0d errors", tests, accepted, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tests
rtl/int_pkg.sv
rtl/fifo_if.sv
rtl/int_math.sv
rtl/pipe_valid_stall.sv
rtl/sync_fifo.sv
rtl/int_unit.sv
tests/int_tb.sv
